// File: tb/alu_golden.txt
// columns: control rs rt tIn hold expVal expT, all hex
// control: bit 5 qword, bit 4 zero extend, bits 3:0 opcode
20 FFFFFFFFFFFFFFFF 0000000000000002 1 0 0000000000000001 1
00 000000007FFFFFFF 0000000000000001 0 0 FFFFFFFF80000000 0
10 12345678FFFFFFFF 0000000000000001 1 0 0000000000000000 1
21 0000000000000000 0000000000000001 0 0 FFFFFFFFFFFFFFFF 0
11 0000000000000010 0000000000000020 1 0 00000000FFFFFFF0 1
22 000000000000FFFF 0000000000000000 1 0 0000000000010000 0
22 00000000FFFFFFFF 0000000000000001 0 0 0000000100000000 0
22 FFFFFFFFFFFFFFFF 0000000000000000 1 0 0000000000000000 1
02 00000000FFFFFFFF 0000000000000000 1 0 0000000000000000 1
02 000000007FFFFFFF 0000000000000000 1 0 FFFFFFFF80000000 0
23 0000000000000000 0000000000000000 1 0 FFFFFFFFFFFFFFFF 1
23 0000000000010000 0000000000000001 1 0 000000000000FFFE 0
23 0000000100000000 0000000000000001 0 0 00000000FFFFFFFF 0
13 0000000000000005 0000000000000005 1 0 00000000FFFFFFFF 1
03 0000000080000000 0000000000000001 0 0 000000007FFFFFFF 0
2C 123456789ABCDEF0 123456789ABCDEF0 0 0 0000000000000000 1
0C 1111111100000005 2222222200000005 0 0 0000000000000000 1
28 1111111100000005 2222222200000005 0 0 0000000000000000 1
29 8000000000000000 0000000000000001 0 0 0000000000000000 1
2A 8000000000000000 0000000000000001 1 0 0000000000000000 0
2E 0000000000000001 8000000000000000 0 0 0000000000000000 1
2D 0000000000000001 8000000000000000 1 0 0000000000000000 0
0D 0000000000000007 0000000000000007 1 0 0000000000000000 0
0E 00000000FFFFFFFF 0000000000000001 1 0 0000000000000000 0
09 00000000FFFFFFFF 0000000000000001 0 0 0000000000000000 1
0A 000000007FFFFFFF 0000000080000000 0 0 0000000000000000 1
24 F0F0000000000000 0F0F000000000000 0 0 0000000000000000 1
04 FF00000000000001 FF00000000000002 0 0 0000000000000000 1
24 FF00000000000001 FF00000000000002 1 0 0000000000000000 0
25 FF00FF00FF00FF00 0FF00FF00FF00FF0 1 0 0F000F000F000F00 1
06 0000000080000000 0000000000000001 0 0 FFFFFFFF80000001 0
27 AAAAAAAAAAAAAAAA FFFFFFFF00000000 0 0 55555555AAAAAAAA 0
2F 1111111111111111 2222222222222222 1 0 1111111111111111 1
2F 1111111111111111 2222222222222222 0 0 2222222222222222 0
0F 0000000000000001 00000000C0000000 0 0 FFFFFFFFC0000000 0
1F 12345678C0000000 0000000000000001 1 0 00000000C0000000 1
2B FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 1 0 0000000000000000 1
20 0000000000000001 0000000000000001 0 1 0000000000000000 1
20 0000000000000001 0000000000000001 0 0 0000000000000002 0

// File: verilog.f
design/aluPkg.sv
design/aluAddCmp.sv
design/aluLogic.sv
design/aluResult.sv
design/exAlu.sv
tb/aluClockGen.sv
tb/exAlu_chk.sv
tb/exAluTb.sv

// File: tb/exAluTb.sv
// integer ALU testbench
// replays golden vectors through the ALU and compares result word and T

`timescale 1ns/100ps
`default_nettype none

module exAluTb;
	import aluPkg::*;

	localparam int maxVecs    = 64;
	localparam int fieldCount = 7;

	logic        clock;
	logic        rstN;
	aluWordT     rsVal;
	aluWordT     rtVal;
	aluCtlT      ctl;
	logic        srT;
	logic        hold;
	aluWordT     resVal;
	logic        resT;

	// ctl, rs, rt, T in, hold, expected value, expected T per vector
	logic [63:0] golden [maxVecs*fieldCount];
	int          vecCount;
	int          cycleCount;
	int          cycleLimit;
	aluWordT     expVal;
	logic        expT;

	aluClockGen u_aluClockGen (
		.clock (clock),
		.rstN  (rstN)
	);

	exAlu u_exAlu (
		.clock  (clock),
		.rstN   (rstN),
		.rsVal  (rsVal),
		.rtVal  (rtVal),
		.ctl    (ctl),
		.srT    (srT),
		.hold   (hold),
		.resVal (resVal),
		.resT   (resT)
	);

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string name, input aluWordT got, input aluWordT exp);
		if (got !== exp) begin
			failRun($sformatf("[ERROR] %s: expected 0x%016h, got 0x%016h", name, exp, got));
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failRun($sformatf("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got));
		end
	endtask

	// run length limit
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			failRun($sformatf("timeout: run still going after %0d cycles", cycleCount));
		end
	end

	always @(posedge clock) begin
		if (u_exAlu.u_exAluChk.assertFails != 0) begin
			failRun("an assertion in the bound output checker failed");
		end
	end

	initial begin
		int idle;
		int base;
		rsVal      = '0;
		rtVal      = '0;
		ctl        = '0;
		srT        = 1'b0;
		hold       = 1'b0;
		cycleCount = 0;
		void'($urandom(10607));
		$readmemh("tb/alu_golden.txt", golden);
		vecCount = 0;
		while (vecCount < maxVecs && !$isunknown(golden[vecCount*fieldCount])) begin
			vecCount++;
		end
		cycleLimit = 16 + 4 * vecCount + 50;
		if (vecCount == 0) begin
			failRun("no vectors could be read from the golden file");
		end

		// registers cleared before the first vector
		wait (rstN === 1'b1);
		checkWord("resVal", resVal, '0);
		checkBit("resT", resT, 1'b0);
		expVal = '0;
		expT   = 1'b0;

		for (int v = 0; v < vecCount; v++) begin
			base = v * fieldCount;
			// a few stalled cycles between vectors
			idle = $urandom % 3;
			repeat (idle) begin
				hold = 1'b1;
				@(posedge clock);
				#2;
			end
			ctl   = golden[base][5:0];
			rsVal = golden[base+1];
			rtVal = golden[base+2];
			srT   = golden[base+3][0];
			hold  = golden[base+4][0];
			// a held vector leaves the last result in place
			if (!hold) begin
				expVal = golden[base+5];
				expT   = golden[base+6][0];
			end
			@(posedge clock);
			#1;
			checkWord("resVal", resVal, expVal);
			checkBit("resT", resT, expT);
			#1;
		end

		hold = 1'b1;
		repeat (2) @(posedge clock);
		#1;
		if (u_exAlu.u_exAluChk.assertFails != 0) begin
			failRun("an assertion in the bound output checker failed");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb/exAlu_chk.sv
// ALU output checker
// reset, hold and T pass-through assertions, bound into the ALU top

`timescale 1ns/100ps
`default_nettype none

module exAluChk (
	input logic            clock,
	input logic            rstN,
	input aluPkg::aluCtlT  ctl,
	input logic            srT,
	input logic            hold,
	input aluPkg::aluWordT resVal,
	input logic            resT
);
	import aluPkg::*;

	int   assertFails = 0;
	logic keepsT;

	// ops that pass T through unchanged
	assign keepsT = (ctl.op == opAdd) || (ctl.op == opSub) || (ctl.op == opAnd)
		|| (ctl.op == opOr) || (ctl.op == opXor) || (ctl.op == opCselT);

	resetClears: assert property (@(posedge clock) !rstN |=> (resVal == '0 && resT == 1'b0))
		else begin
			assertFails++;
			$error("outputs not cleared one cycle after reset");
		end

	holdFreezes: assert property (@(posedge clock) disable iff (!rstN)
		hold |=> ($stable(resVal) && $stable(resT)))
		else begin
			assertFails++;
			$error("outputs changed across an edge with hold high");
		end

	tPassThrough: assert property (@(posedge clock) disable iff (!rstN)
		(!hold && keepsT) |=> (resT == $past(srT)))
		else begin
			assertFails++;
			$error("T not passed through for a T-neutral operation");
		end

endmodule

bind exAlu exAluChk u_exAluChk (
	.clock  (clock),
	.rstN   (rstN),
	.ctl    (ctl),
	.srT    (srT),
	.hold   (hold),
	.resVal (resVal),
	.resT   (resT)
);

`default_nettype wire

// File: tb/aluClockGen.sv
// testbench clock and reset
// 40 ns clock, reset held low for the first 16 cycles

`timescale 1ns/100ps
`default_nettype none

module aluClockGen (
	output logic clock,
	output logic rstN
);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// release just after the 16th rising edge
	initial begin
		rstN = 1'b0;
		repeat (16) @(posedge clock);
		#2;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: design/exAlu.sv
// execute unit integer ALU
// add/compare and logic units feeding a one-cycle result stage

`timescale 1ns/100ps
`default_nettype none

module exAlu (
	input  logic            clock,
	input  logic            rstN,
	input  aluPkg::aluWordT rsVal,
	input  aluPkg::aluWordT rtVal,
	input  aluPkg::aluCtlT  ctl,
	input  logic            srT,
	input  logic            hold,
	output aluPkg::aluWordT resVal,
	output logic            resT
);
	import aluPkg::*;

	aluArithT arith;
	aluLogicT logicRes;

	aluAddCmp u_aluAddCmp (
		.rsVal (rsVal),
		.rtVal (rtVal),
		.srT   (srT),
		.arith (arith)
	);

	aluLogic u_aluLogic (
		.rsVal    (rsVal),
		.rtVal    (rtVal),
		.srT      (srT),
		.logicRes (logicRes)
	);

	aluResult u_aluResult (
		.clock    (clock),
		.rstN     (rstN),
		.ctl      (ctl),
		.srT      (srT),
		.hold     (hold),
		.arith    (arith),
		.logicRes (logicRes),
		.resVal   (resVal),
		.resT     (resT)
	);

endmodule

`default_nettype wire

// File: design/aluResult.sv
// ALU result stage
// opcode decode, width and extension, registered result with hold

`timescale 1ns/100ps
`default_nettype none

module aluResult (
	input  logic             clock,
	input  logic             rstN,
	input  aluPkg::aluCtlT   ctl,
	input  logic             srT,
	input  logic             hold,
	input  aluPkg::aluArithT arith,
	input  aluPkg::aluLogicT logicRes,
	output aluPkg::aluWordT  resVal,
	output logic             resT
);
	import aluPkg::*;

	aluFlagsT flg;
	logic     signedGe;
	aluWordT  rawVal;
	aluHalfT  laneVal;
	aluWordT  nextVal;
	logic     nextT;

	// flags of the selected width
	assign flg      = ctl.qWord ? arith.flags64 : arith.flags32;
	assign signedGe = ~(flg.sign ^ flg.overflow);

	always_comb begin
		rawVal = '0;
		nextT  = srT;
		case (ctl.op)
			opAdd: rawVal = arith.addSum;
			opSub: rawVal = arith.subDiff;
			opAdc: begin
				rawVal = srT ? arith.addSumC : arith.addSum;
				nextT  = ctl.qWord ? arith.addCarry64 : arith.addCarry32;
			end
			opSbb: begin
				rawVal = srT ? arith.subDiffB : arith.subDiff;
				// borrow out is the inverted carry
				nextT  = ctl.qWord ? ~arith.subCarry64 : ~arith.subCarry32;
			end
			opTst:   nextT = ctl.qWord ? logicRes.tstZero64 : logicRes.tstZero32;
			opAnd:   rawVal = logicRes.andVal;
			opOr:    rawVal = logicRes.orVal;
			opXor:   rawVal = logicRes.xorVal;
			opCmpNe: nextT = ~flg.zero;
			opCmpHs: nextT = flg.carry;
			opCmpGe: nextT = signedGe;
			// reserved op gives zero and keeps T
			opNor:   nextT = srT;
			opCmpEq: nextT = flg.zero;
			opCmpHi: nextT = flg.carry & ~flg.zero;
			opCmpGt: nextT = signedGe & ~flg.zero;
			opCselT: rawVal = logicRes.selVal;
		endcase
	end

	// 32-bit results get zero or sign extended
	assign laneVal = rawVal[31:0];

	always_comb begin
		if (ctl.qWord) begin
			nextVal = rawVal;
		end else if (ctl.zeroExt) begin
			nextVal = {32'h0, laneVal};
		end else begin
			nextVal = {{32{laneVal[31]}}, laneVal};
		end
	end

	// output register frozen while held
	always_ff @(posedge clock) begin
		if (!rstN) begin
			resVal <= '0;
			resT   <= 1'b0;
		end else if (!hold) begin
			resVal <= nextVal;
			resT   <= nextT;
		end
	end

endmodule

`default_nettype wire

// File: design/aluLogic.sv
// ALU bitwise and select unit
// and/or/xor words, TST zero detect and T-controlled operand select

`timescale 1ns/100ps
`default_nettype none

module aluLogic (
	input  aluPkg::aluWordT  rsVal,
	input  aluPkg::aluWordT  rtVal,
	input  logic             srT,
	output aluPkg::aluLogicT logicRes
);
	import aluPkg::*;

	aluWordT    andWord;
	logic [3:0] andZero;

	assign andWord = rsVal & rtVal;

	assign logicRes.andVal = andWord;
	assign logicRes.orVal  = rsVal | rtVal;
	assign logicRes.xorVal = rsVal ^ rtVal;

	// cselt: rs when T set
	assign logicRes.selVal = srT ? rsVal : rtVal;

	// per-block zero detect of rs & rt
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			andZero[b] = (andWord[16*b +: 16] == 16'h0);
		end
	end

	assign logicRes.tstZero32 = andZero[0] & andZero[1];
	assign logicRes.tstZero64 = andZero[0] & andZero[1] & andZero[2] & andZero[3];

endmodule

`default_nettype wire

// File: design/aluAddCmp.sv
// ALU arithmetic and compare unit
// carry-select add and subtract, flags of rs - rt at 32 and 64 bits

`timescale 1ns/100ps
`default_nettype none

module aluAddCmp (
	input  aluPkg::aluWordT  rsVal,
	input  aluPkg::aluWordT  rtVal,
	input  logic             srT,
	output aluPkg::aluArithT arith
);
	import aluPkg::*;

	// index 0 adds rt, index 1 adds ~rt
	aluWordT     rtOpd [2];

	// [kind][carry in][16-bit block]
	logic [16:0] blkSum [2][2][4];
	// [kind][carry in]
	logic [32:0] loSum [2][2];
	logic [32:0] hiSum [2][2];
	logic [64:0] fullSum [2][2];

	aluWordT     diff;
	aluHalfT     diffLo;
	logic [3:0]  partZero;
	logic        zero32;
	logic        zero64;

	// block carry picks which upper half is taken
	function automatic logic [32:0] join32(
		input logic [16:0] lo,
		input logic [16:0] hi0,
		input logic [16:0] hi1
	);
		join32 = {lo[16] ? hi1 : hi0, lo[15:0]};
	endfunction

	function automatic logic [64:0] join64(
		input logic [32:0] lo,
		input logic [32:0] hi0,
		input logic [32:0] hi1
	);
		join64 = {lo[32] ? hi1 : hi0, lo[31:0]};
	endfunction

	assign rtOpd[0] = rtVal;
	assign rtOpd[1] = ~rtVal;

	// both carry-in variants of every 16-bit block
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			for (int c = 0; c < 2; c++) begin
				for (int b = 0; b < 4; b++) begin
					blkSum[k][c][b] = {1'b0, rsVal[16*b +: 16]}
						+ {1'b0, rtOpd[k][16*b +: 16]} + 17'(c);
				end
			end
		end
	end

	// join blocks into halves, then halves into words
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			for (int c = 0; c < 2; c++) begin
				loSum[k][c] = join32(blkSum[k][c][0], blkSum[k][0][1], blkSum[k][1][1]);
				hiSum[k][c] = join32(blkSum[k][c][2], blkSum[k][0][3], blkSum[k][1][3]);
			end
			for (int c = 0; c < 2; c++) begin
				fullSum[k][c] = join64(loSum[k][c], hiSum[k][0], hiSum[k][1]);
			end
		end
	end

	assign arith.addSum   = fullSum[0][0][63:0];
	assign arith.addSumC  = fullSum[0][1][63:0];
	// rs + ~rt + 1 is the plain difference
	assign arith.subDiff  = fullSum[1][1][63:0];
	assign arith.subDiffB = fullSum[1][0][63:0];

	// carry out for adc/sbb with the incoming T
	assign arith.addCarry32 = srT ? loSum[0][1][32] : loSum[0][0][32];
	assign arith.addCarry64 = srT ? fullSum[0][1][64] : fullSum[0][0][64];
	assign arith.subCarry32 = srT ? loSum[1][0][32] : loSum[1][1][32];
	assign arith.subCarry64 = srT ? fullSum[1][0][64] : fullSum[1][1][64];

	// compare flags
	assign diff   = fullSum[1][1][63:0];
	assign diffLo = diff[31:0];

	always_comb begin
		for (int b = 0; b < 4; b++) begin
			partZero[b] = (diff[16*b +: 16] == 16'h0);
		end
	end

	assign zero32 = partZero[0] & partZero[1];
	assign zero64 = zero32 & partZero[2] & partZero[3];

	assign arith.flags32.zero     = zero32;
	assign arith.flags32.carry    = loSum[1][1][32];
	assign arith.flags32.sign     = diffLo[31];
	// signs differ and result sign left rs
	assign arith.flags32.overflow = (rsVal[31] ^ rtVal[31]) & (diffLo[31] ^ rsVal[31]);

	assign arith.flags64.zero     = zero64;
	assign arith.flags64.carry    = fullSum[1][1][64];
	assign arith.flags64.sign     = diff[63];
	assign arith.flags64.overflow = (rsVal[63] ^ rtVal[63]) & (diff[63] ^ rsVal[63]);

endmodule

`default_nettype wire

// File: design/aluPkg.sv
// ALU package
// word types, control byte layout, opcodes and unit result structs

`default_nettype none

package aluPkg;

	// register word and its low half
	typedef logic [63:0] aluWordT;
	typedef logic [31:0] aluHalfT;

	typedef logic [3:0] aluOpT;

	// opcodes
	localparam aluOpT opAdd   = 4'h0;
	localparam aluOpT opSub   = 4'h1;
	localparam aluOpT opAdc   = 4'h2;
	localparam aluOpT opSbb   = 4'h3;
	localparam aluOpT opTst   = 4'h4;
	localparam aluOpT opAnd   = 4'h5;
	localparam aluOpT opOr    = 4'h6;
	localparam aluOpT opXor   = 4'h7;
	localparam aluOpT opCmpNe = 4'h8;
	localparam aluOpT opCmpHs = 4'h9;
	localparam aluOpT opCmpGe = 4'hA;
	localparam aluOpT opNor   = 4'hB; // reserved
	localparam aluOpT opCmpEq = 4'hC;
	localparam aluOpT opCmpHi = 4'hD;
	localparam aluOpT opCmpGt = 4'hE;
	localparam aluOpT opCselT = 4'hF;

	// control byte, bit 5 = qword, bit 4 = zero extend, 3:0 = op
	typedef struct packed {
		logic  qWord;
		logic  zeroExt;
		aluOpT op;
	} aluCtlT;

	// flags of rs - rt at one width
	typedef struct packed {
		logic zero;
		logic carry;
		logic sign;
		logic overflow;
	} aluFlagsT;

	// arithmetic and compare unit outputs
	typedef struct packed {
		aluWordT  addSum;
		aluWordT  addSumC;
		aluWordT  subDiff;
		aluWordT  subDiffB;
		logic     addCarry32;
		logic     addCarry64;
		logic     subCarry32;
		logic     subCarry64;
		aluFlagsT flags32;
		aluFlagsT flags64;
	} aluArithT;

	// bitwise and select unit outputs
	typedef struct packed {
		aluWordT andVal;
		aluWordT orVal;
		aluWordT xorVal;
		aluWordT selVal;
		logic    tstZero32;
		logic    tstZero64;
	} aluLogicT;

endpackage

`default_nettype wire
